//--- common/timing_pkg.sv
package timing_pkg;

	// one beam orbit in clock127 cycles
	localparam int BUCKETS_PER_ORBIT = 1280;

	// orbits grouped into one superframe
	localparam int ORBITS_PER_SUPERFRAME = 9;

	localparam int BUCKET_WIDTH = 11; // enough for 0..1279

	// rf bucket number within the orbit
	typedef logic [BUCKET_WIDTH-1:0] bucket_t;

	// one-hot orbit marker, msb is orbit 0, lsb is orbit 8
	typedef logic [ORBITS_PER_SUPERFRAME-1:0] orbit_token_t;

	localparam bucket_t LAST_BUCKET = bucket_t'(BUCKETS_PER_ORBIT - 1);

	// token values for the first and last orbit of a superframe
	localparam orbit_token_t TOKEN_ORBIT_FIRST = {1'b1, {(ORBITS_PER_SUPERFRAME - 1){1'b0}}};
	localparam orbit_token_t TOKEN_ORBIT_LAST = orbit_token_t'(1);

endpackage

//--- common/trigger_config_pkg.sv
package trigger_config_pkg;

	localparam int NUM_MARKERS = 4; // markers a to d

	localparam int POSITION_WIDTH = 25;

	// orbit mask field, same bit order as the orbit token
	localparam int MASK_MSB = 24;
	localparam int MASK_LSB = 16;

	// bucket field
	localparam int BUCKET_MSB = 12;
	localparam int BUCKET_LSB = 2;

	localparam int PRESCALE_WIDTH = 5;

	// bunch marker config word, bits 15..13 and 1..0 unused
	typedef logic [POSITION_WIDTH-1:0] marker_position_t;

	// N of the 2^N superframe prescale
	typedef logic [PRESCALE_WIDTH-1:0] prescale_log2_t;

endpackage

//--- filelist.f
common/timing_pkg.sv
common/trigger_config_pkg.sv
hdl/orbit_timer.sv
trigger/trigger_config_latch.sv
trigger/superframe_prescaler.sv
trigger/bunch_marker_matcher.sv
hdl/xrm_trigger_top.sv
test/xrm_trigger_checker.sv
test/xrm_trigger_tb.sv

//--- hdl/orbit_timer.sv
`timescale 1ns/1ps

module orbit_timer (
	input logic clock127,
	input logic reset,
	input logic revo,
	output timing_pkg::bucket_t bucket_count,
	output timing_pkg::orbit_token_t orbit_token,
	output logic superframe_wrap,
	output logic frame,
	output logic frame9
);

	logic orbit_end;
	timing_pkg::orbit_token_t next_token;
	logic last_orbit;

	// revo forces an early orbit end, otherwise wrap at the last bucket
	assign orbit_end = revo || (bucket_count == timing_pkg::LAST_BUCKET);

	// rotate toward lsb, orbit 8 wraps back to orbit 0
	assign next_token = {orbit_token[0],
		orbit_token[timing_pkg::ORBITS_PER_SUPERFRAME-1:1]};

	assign last_orbit = (orbit_token == timing_pkg::TOKEN_ORBIT_LAST);

	// high in the final cycle of orbit 8
	assign superframe_wrap = orbit_end && last_orbit;

	always_ff @(posedge clock127) begin
		if (reset) begin
			bucket_count <= '0;
			orbit_token <= timing_pkg::TOKEN_ORBIT_LAST; // first orbit end starts orbit 0
			frame <= 1'b0;
			frame9 <= 1'b0;
		end else begin
			frame <= orbit_end; // lines up with bucket 0
			frame9 <= orbit_end && (next_token == timing_pkg::TOKEN_ORBIT_FIRST);
			if (orbit_end) begin
				bucket_count <= '0;
				orbit_token <= next_token;
			end else begin
				bucket_count <= bucket_count + 1'b1;
			end
		end
	end

endmodule

//--- hdl/xrm_trigger_top.sv
`timescale 1ns/1ps

module xrm_trigger_top (
	input logic clock127,
	input logic reset,
	input logic revo,
	input logic trigger_enable,
	input trigger_config_pkg::prescale_log2_t prescale_log2,
	input trigger_config_pkg::marker_position_t marker_a_position,
	input trigger_config_pkg::marker_position_t marker_b_position,
	input trigger_config_pkg::marker_position_t marker_c_position,
	input trigger_config_pkg::marker_position_t marker_d_position,
	output logic xrm_trigger,
	output logic frame,
	output logic frame9
);

	timing_pkg::bucket_t bucket_count;
	timing_pkg::orbit_token_t orbit_token;
	logic superframe_wrap;
	logic held_enable;
	trigger_config_pkg::prescale_log2_t held_prescale_log2;
	trigger_config_pkg::marker_position_t held_a_position;
	trigger_config_pkg::marker_position_t held_b_position;
	trigger_config_pkg::marker_position_t held_c_position;
	trigger_config_pkg::marker_position_t held_d_position;
	logic trigger_window;

	orbit_timer u_orbit_timer (
		.clock127(clock127),
		.reset(reset),
		.revo(revo),
		.bucket_count(bucket_count),
		.orbit_token(orbit_token),
		.superframe_wrap(superframe_wrap),
		.frame(frame),
		.frame9(frame9)
	);

	trigger_config_latch u_config_latch (
		.clock127(clock127),
		.reset(reset),
		.superframe_wrap(superframe_wrap),
		.trigger_enable(trigger_enable),
		.prescale_log2(prescale_log2),
		.marker_a_position(marker_a_position),
		.marker_b_position(marker_b_position),
		.marker_c_position(marker_c_position),
		.marker_d_position(marker_d_position),
		.held_enable(held_enable),
		.held_prescale_log2(held_prescale_log2),
		.held_a_position(held_a_position),
		.held_b_position(held_b_position),
		.held_c_position(held_c_position),
		.held_d_position(held_d_position)
	);

	superframe_prescaler u_prescaler (
		.clock127(clock127),
		.reset(reset),
		.superframe_wrap(superframe_wrap),
		.held_enable(held_enable),
		.held_prescale_log2(held_prescale_log2),
		.trigger_window(trigger_window)
	);

	bunch_marker_matcher u_matcher (
		.clock127(clock127),
		.reset(reset),
		.trigger_window(trigger_window),
		.bucket_count(bucket_count),
		.orbit_token(orbit_token),
		.held_a_position(held_a_position),
		.held_b_position(held_b_position),
		.held_c_position(held_c_position),
		.held_d_position(held_d_position),
		.xrm_trigger(xrm_trigger)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the xrm trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module xrm_trigger_tb -f filelist.f -o sim_xrm_trigger
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

# let every assertion failure reach the testbench
output=$(./obj_dir/sim_xrm_trigger +verilator+error+limit+100 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
echo "pass message not found"
exit 1

//--- test/xrm_trigger_checker.sv
`timescale 1ns/1ps

module xrm_trigger_checker (
	input logic clock127,
	input logic reset,
	input logic superframe_wrap,
	input logic frame,
	input logic frame9,
	input logic xrm_trigger
);

	int failure_count = 0; // failed assertions so far
	logic wrap_seen;
	int frame_gap; // cycles since the last frame strobe

	always_ff @(posedge clock127) begin
		if (reset) begin
			wrap_seen <= 1'b0;
			frame_gap <= 0;
		end else begin
			if (superframe_wrap) begin
				wrap_seen <= 1'b1;
			end
			frame_gap <= frame ? 1 : frame_gap + 1;
		end
	end

	frame_single_cycle: assert property (@(posedge clock127) disable iff (reset)
		frame |=> !frame)
		else begin
			$error("frame high in two consecutive cycles");
			failure_count++;
		end

	frame9_with_frame: assert property (@(posedge clock127) disable iff (reset)
		frame9 |-> frame)
		else begin
			$error("frame9 without frame");
			failure_count++;
		end

	// window is closed until the first superframe boundary
	no_early_trigger: assert property (@(posedge clock127) disable iff (reset)
		!wrap_seen |-> !xrm_trigger)
		else begin
			$error("xrm_trigger before the first superframe wrap");
			failure_count++;
		end

	orbit_length_bound: assert property (@(posedge clock127) disable iff (reset)
		frame_gap <= timing_pkg::BUCKETS_PER_ORBIT)
		else begin
			$error("no frame within one orbit length");
			failure_count++;
		end

endmodule

//--- test/xrm_trigger_tb.sv
`timescale 1ns/1ps

module xrm_trigger_tb;

	localparam int CLOCK_PERIOD = 8;
	localparam int RUN_SUPERFRAMES = 20;
	localparam int SUPERFRAME_CYCLES =
		timing_pkg::ORBITS_PER_SUPERFRAME * timing_pkg::BUCKETS_PER_ORBIT;
	localparam real WATCHDOG_NS = 1.5 * RUN_SUPERFRAMES * SUPERFRAME_CYCLES * CLOCK_PERIOD;

	logic clock127;
	logic reset;
	logic revo;
	logic trigger_enable;
	trigger_config_pkg::prescale_log2_t prescale_log2;
	trigger_config_pkg::marker_position_t marker_a_position;
	trigger_config_pkg::marker_position_t marker_b_position;
	trigger_config_pkg::marker_position_t marker_c_position;
	trigger_config_pkg::marker_position_t marker_d_position;
	logic xrm_trigger;
	logic frame;
	logic frame9;

	integer seed;

	// reference model state
	int model_bucket;
	int model_orbit; // 0 to 8 within the superframe
	logic orbit_end;
	logic wrap;
	logic exp_frame;
	logic exp_frame9;
	logic exp_trigger;
	logic held_enable;
	trigger_config_pkg::prescale_log2_t held_prescale;
	trigger_config_pkg::marker_position_t held_position [4];
	logic [31:0] sf_count;
	logic [31:0] sf_threshold;
	logic window;
	int trigger_count;

	xrm_trigger_top UUT (
		.clock127(clock127),
		.reset(reset),
		.revo(revo),
		.trigger_enable(trigger_enable),
		.prescale_log2(prescale_log2),
		.marker_a_position(marker_a_position),
		.marker_b_position(marker_b_position),
		.marker_c_position(marker_c_position),
		.marker_d_position(marker_d_position),
		.xrm_trigger(xrm_trigger),
		.frame(frame),
		.frame9(frame9)
	);

	bind xrm_trigger_top xrm_trigger_checker u_checker (
		.clock127(clock127),
		.reset(reset),
		.superframe_wrap(superframe_wrap),
		.frame(frame),
		.frame9(frame9),
		.xrm_trigger(xrm_trigger)
	);

	initial begin
		clock127 = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock127 = ~clock127;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_strobe(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			abort_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_bucket(input string name, input timing_pkg::bucket_t actual,
		input timing_pkg::bucket_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	function automatic int random_below(input int span);
		return $unsigned($random(seed)) % span;
	endfunction

	function automatic trigger_config_pkg::marker_position_t make_position(
		input timing_pkg::orbit_token_t mask, input int bucket);
		trigger_config_pkg::marker_position_t position;
		position = '0;
		position[trigger_config_pkg::MASK_MSB:trigger_config_pkg::MASK_LSB] = mask;
		position[trigger_config_pkg::BUCKET_MSB:trigger_config_pkg::BUCKET_LSB] =
			timing_pkg::bucket_t'(bucket);
		return position;
	endfunction

	// first marker whose bucket matches is the only one tested
	function automatic logic expected_trigger(input int bucket, input int orbit,
		input logic window_open,
		input trigger_config_pkg::marker_position_t pos_a,
		input trigger_config_pkg::marker_position_t pos_b,
		input trigger_config_pkg::marker_position_t pos_c,
		input trigger_config_pkg::marker_position_t pos_d);
		trigger_config_pkg::marker_position_t pos [4];
		logic found;
		logic result;
		pos[0] = pos_a;
		pos[1] = pos_b;
		pos[2] = pos_c;
		pos[3] = pos_d;
		found = 1'b0;
		result = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (!found && int'(pos[i][trigger_config_pkg::BUCKET_MSB:
				trigger_config_pkg::BUCKET_LSB]) == bucket) begin
				found = 1'b1;
				// mask msb is orbit 0
				result = window_open && pos[i][trigger_config_pkg::MASK_LSB
					+ timing_pkg::ORBITS_PER_SUPERFRAME - 1 - orbit];
			end
		end
		return result;
	endfunction

	task automatic next_cycle();
		@(posedge clock127);
		#1;
	endtask

	// returns in the first cycle of a new superframe
	task automatic wait_superframes(input int count);
		repeat (count) begin
			next_cycle();
			while (frame9 !== 1'b1) begin
				next_cycle();
			end
		end
	endtask

	task automatic wait_random(input int least, input int span);
		repeat (least + random_below(span)) next_cycle();
	endtask

	task automatic pulse_revo();
		while (frame) begin
			next_cycle(); // keep frame strobes apart
		end
		revo = 1'b1;
		next_cycle();
		revo = 1'b0;
	endtask

	task automatic randomize_markers();
		int shared_bucket;
		shared_bucket = random_below(timing_pkg::BUCKETS_PER_ORBIT);
		marker_a_position = make_position(timing_pkg::orbit_token_t'($random(seed)),
			shared_bucket);
		// half the time b sits behind a at the same bucket
		marker_b_position = make_position(timing_pkg::orbit_token_t'($random(seed)),
			random_below(2) ? shared_bucket : random_below(timing_pkg::BUCKETS_PER_ORBIT));
		marker_c_position = make_position(timing_pkg::orbit_token_t'($random(seed)),
			random_below(timing_pkg::BUCKETS_PER_ORBIT));
		marker_d_position = make_position(timing_pkg::orbit_token_t'($random(seed)),
			random_below(timing_pkg::BUCKETS_PER_ORBIT));
	endtask

	always @(posedge clock127) begin
		if (reset) begin
			model_bucket = 0;
			model_orbit = timing_pkg::ORBITS_PER_SUPERFRAME - 1;
			exp_frame = 1'b0;
			exp_frame9 = 1'b0;
			exp_trigger = 1'b0;
			held_enable = 1'b0;
			held_prescale = '0;
			for (int i = 0; i < 4; i++) begin
				held_position[i] = '0;
			end
			sf_count = 32'd1;
			sf_threshold = 32'd1;
			window = 1'b0;
		end else begin
			orbit_end = revo || (model_bucket == timing_pkg::BUCKETS_PER_ORBIT - 1);
			wrap = orbit_end && (model_orbit == timing_pkg::ORBITS_PER_SUPERFRAME - 1);
			exp_trigger = expected_trigger(model_bucket, model_orbit, window,
				held_position[0], held_position[1], held_position[2], held_position[3]);
			exp_frame = orbit_end;
			exp_frame9 = wrap; // next orbit is orbit 0
			if (orbit_end) begin
				model_bucket = 0;
				model_orbit = (model_orbit + 1) % timing_pkg::ORBITS_PER_SUPERFRAME;
			end else begin
				model_bucket = model_bucket + 1;
			end
			if (wrap) begin
				window = 1'b0;
				if (held_enable) begin // enable of the ending superframe
					if (sf_count < sf_threshold) begin
						sf_count = sf_count + 32'd1;
					end else begin
						sf_count = 32'd1;
						window = 1'b1;
					end
				end
				sf_threshold = 32'd1 << held_prescale;
				held_enable = trigger_enable;
				held_prescale = prescale_log2;
				held_position[0] = marker_a_position;
				held_position[1] = marker_b_position;
				held_position[2] = marker_c_position;
				held_position[3] = marker_d_position;
			end
		end
	end

	// outputs are settled at the falling edge
	always @(negedge clock127) begin
		if (reset === 1'b0) begin
			check_bucket("bucket_count", UUT.bucket_count, timing_pkg::bucket_t'(model_bucket));
			check_strobe("frame", frame, exp_frame);
			check_strobe("frame9", frame9, exp_frame9);
			check_strobe("xrm_trigger", xrm_trigger, exp_trigger);
			if (UUT.u_checker.failure_count != 0) begin
				abort_run($sformatf("a bound assertion failed before %0t ns", $time));
			end
			if (exp_trigger) begin
				trigger_count++;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("simulation timed out at %0t ns", $time));
	end

	initial begin
		seed = 2713;
		trigger_count = 0;
		reset = 1'b1;
		revo = 1'b0;
		trigger_enable = 1'b0;
		prescale_log2 = '0;
		marker_a_position = '0;
		marker_b_position = '0;
		marker_c_position = '0;
		marker_d_position = '0;
		repeat (3) @(posedge clock127);
		#1;
		reset = 1'b0;

		// a and b share bucket 100, so b is never tested
		trigger_enable = 1'b1;
		marker_a_position = make_position(9'b101010101, 100); // even orbits
		marker_b_position = make_position(9'b111111111, 100);
		marker_c_position = make_position(9'b010000000, 500); // orbit 1 only
		marker_d_position = make_position(9'b000000001, 1279); // end of orbit 8
		wait_superframes(3);

		// random markers, orbits cut short by revo
		for (int sf = 0; sf < 3; sf++) begin
			wait_random(500, 3000);
			randomize_markers();
			repeat (8) begin
				wait_random(100, 1000);
				pulse_revo();
			end
		end
		wait_superframes(1);

		// prescale changes land mid superframe
		wait_random(1000, 8000);
		prescale_log2 = trigger_config_pkg::prescale_log2_t'(1);
		marker_a_position = make_position(9'h1ff, random_below(timing_pkg::BUCKETS_PER_ORBIT));
		wait_superframes(5);
		wait_random(1000, 8000);
		prescale_log2 = trigger_config_pkg::prescale_log2_t'(2);
		wait_superframes(6);

		// long enough for the counter to reach 2^N while disabled
		wait_random(1000, 8000);
		trigger_enable = 1'b0;
		wait_superframes(4);

		if (trigger_count == 0) begin
			abort_run("no trigger was expected during the run, markers never matched");
		end else if (UUT.u_checker.failure_count != 0) begin
			abort_run("a bound assertion failed in the last cycle of the run");
		end else begin
			$display("%0d triggers compared", trigger_count);
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- trigger/bunch_marker_matcher.sv
`timescale 1ns/1ps

module bunch_marker_matcher (
	input logic clock127,
	input logic reset,
	input logic trigger_window,
	input timing_pkg::bucket_t bucket_count,
	input timing_pkg::orbit_token_t orbit_token,
	input trigger_config_pkg::marker_position_t held_a_position,
	input trigger_config_pkg::marker_position_t held_b_position,
	input trigger_config_pkg::marker_position_t held_c_position,
	input trigger_config_pkg::marker_position_t held_d_position,
	output logic xrm_trigger
);

	trigger_config_pkg::marker_position_t positions [trigger_config_pkg::NUM_MARKERS];
	logic [trigger_config_pkg::NUM_MARKERS-1:0] bucket_hit;
	logic [trigger_config_pkg::NUM_MARKERS-1:0] orbit_hit;
	logic [trigger_config_pkg::NUM_MARKERS-1:0] fire_next;
	logic [trigger_config_pkg::NUM_MARKERS-1:0] fire;

	// index 0 has top priority
	assign positions[0] = held_a_position;
	assign positions[1] = held_b_position;
	assign positions[2] = held_c_position;
	assign positions[3] = held_d_position;

	always_comb begin
		for (int i = 0; i < trigger_config_pkg::NUM_MARKERS; i++) begin
			bucket_hit[i] = (bucket_count == timing_pkg::bucket_t'(
				positions[i][trigger_config_pkg::BUCKET_MSB:trigger_config_pkg::BUCKET_LSB]));
			orbit_hit[i] = |(orbit_token & timing_pkg::orbit_token_t'(
				positions[i][trigger_config_pkg::MASK_MSB:trigger_config_pkg::MASK_LSB]));
		end
	end

	// first bucket match wins, later markers at the same bucket are ignored
	always_comb begin
		logic claimed;
		claimed = 1'b0;
		fire_next = '0;
		for (int i = 0; i < trigger_config_pkg::NUM_MARKERS; i++) begin
			if (!claimed && bucket_hit[i]) begin
				claimed = 1'b1;
				fire_next[i] = trigger_window && orbit_hit[i];
			end
		end
	end

	always_ff @(posedge clock127) begin
		if (reset) begin
			fire <= '0;
		end else begin
			fire <= fire_next; // one cycle after the bucket
		end
	end

	assign xrm_trigger = |fire;

endmodule

//--- trigger/superframe_prescaler.sv
`timescale 1ns/1ps

module superframe_prescaler (
	input logic clock127,
	input logic reset,
	input logic superframe_wrap,
	input logic held_enable,
	input trigger_config_pkg::prescale_log2_t held_prescale_log2,
	output logic trigger_window
);

	logic [31:0] superframe_count; // enabled superframes since last open window
	logic [31:0] threshold; // 2^N

	always_ff @(posedge clock127) begin
		if (reset) begin
			superframe_count <= 32'd1;
			threshold <= 32'd1; // 2^0, first enabled decision opens
			trigger_window <= 1'b0;
		end else if (superframe_wrap) begin
			trigger_window <= 1'b0;
			if (held_enable) begin
				if (superframe_count < threshold) begin
					superframe_count <= superframe_count + 32'd1;
				end else begin
					// reached 2^N, open for the coming superframe
					superframe_count <= 32'd1;
					trigger_window <= 1'b1;
				end
			end
			// applies from the next decision on
			threshold <= 32'd1 << held_prescale_log2;
		end
	end

endmodule

//--- trigger/trigger_config_latch.sv
`timescale 1ns/1ps

module trigger_config_latch (
	input logic clock127,
	input logic reset,
	input logic superframe_wrap,
	input logic trigger_enable,
	input trigger_config_pkg::prescale_log2_t prescale_log2,
	input trigger_config_pkg::marker_position_t marker_a_position,
	input trigger_config_pkg::marker_position_t marker_b_position,
	input trigger_config_pkg::marker_position_t marker_c_position,
	input trigger_config_pkg::marker_position_t marker_d_position,
	output logic held_enable,
	output trigger_config_pkg::prescale_log2_t held_prescale_log2,
	output trigger_config_pkg::marker_position_t held_a_position,
	output trigger_config_pkg::marker_position_t held_b_position,
	output trigger_config_pkg::marker_position_t held_c_position,
	output trigger_config_pkg::marker_position_t held_d_position
);

	// config bus writes can land anywhere in a superframe,
	// so the trigger logic only ever sees these copies
	always_ff @(posedge clock127) begin
		if (reset) begin
			held_enable <= 1'b0;
			held_prescale_log2 <= '0;
			held_a_position <= '0;
			held_b_position <= '0;
			held_c_position <= '0;
			held_d_position <= '0;
		end else if (superframe_wrap) begin // take new values at the boundary only
			held_enable <= trigger_enable;
			held_prescale_log2 <= prescale_log2;
			held_a_position <= marker_a_position;
			held_b_position <= marker_b_position;
			held_c_position <= marker_c_position;
			held_d_position <= marker_d_position;
		end
	end

endmodule
